//--- udp_echo_settings.svh
`ifndef UDP_ECHO_SETTINGS_SVH
`define UDP_ECHO_SETTINGS_SVH

// Destination port answered by the echo core
`define UDP_ECHO_PORT 16'd1234

// Own address 192.168.1.128
`define UDP_LOCAL_IP 32'hc0a8_0180

// TTL placed in every reply
`define UDP_REPLY_TTL 8'd64

// Payload FIFO entries as a power of two of at least 2
`define UDP_FIFO_DEPTH 32

// Payload beat width
`define UDP_DATA_W 8

`endif

//--- udp_echo_pkg.sv
`include "udp_echo_settings.svh"

package udp_echo_pkg;

    // Parsed UDP datagram header, one beat per datagram
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
        logic [7:0]  ttl;
    } udp_hdr_t;

    // One payload byte with end of frame marker
    typedef struct packed {
        logic [`UDP_DATA_W-1:0] data;
        logic                   last;
    } axis_byte_t;

    // Per-datagram payload handling
    typedef enum logic [1:0] {
        STEER_IDLE = 2'd0,
        STEER_ECHO = 2'd1,
        STEER_DROP = 2'd2
    } steer_state_e;

endpackage

//--- udp_payload_fifo.sv
`timescale 1ns/1ps

module udp_payload_fifo #(
    parameter int DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,

    input  udp_echo_pkg::axis_byte_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,

    output udp_echo_pkg::axis_byte_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);

    localparam int AW = $clog2(DEPTH);

    udp_echo_pkg::axis_byte_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    assign in_ready  = (count != DEPTH[AW:0]);
    assign out_valid = (count != '0);
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    // Head entry sits in a storage register and shows the cycle after its write
    assign out_beat = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Occupancy stays unchanged on a simultaneous push and pop
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- udp_echo_steer.sv
`timescale 1ns/1ps

`include "udp_echo_settings.svh"

module udp_echo_steer (
    input  logic                     clk,
    input  logic                     rst,

    input  udp_echo_pkg::udp_hdr_t   rx_hdr,
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,

    input  udp_echo_pkg::axis_byte_t rx_pay,
    input  logic                     rx_pay_valid,
    output logic                     rx_pay_ready,

    output udp_echo_pkg::udp_hdr_t   tx_hdr,
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,

    output udp_echo_pkg::axis_byte_t fifo_in,
    output logic                     fifo_in_valid,
    input  logic                     fifo_in_ready
);

    udp_echo_pkg::steer_state_e state;

    logic port_match;
    logic in_idle;
    logic hdr_xfer;
    logic pay_last_xfer;

    assign port_match = (rx_hdr.dst_port == `UDP_ECHO_PORT);
    assign in_idle    = (state == udp_echo_pkg::STEER_IDLE);

    // Matching headers wait for the reply sink, others are absorbed at once
    assign tx_hdr_valid = in_idle && rx_hdr_valid && port_match;
    assign rx_hdr_ready = in_idle && (port_match ? tx_hdr_ready : 1'b1);
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;

    // Reply header
    always_comb begin
        tx_hdr          = '0;
        tx_hdr.src_ip   = `UDP_LOCAL_IP;
        tx_hdr.dst_ip   = rx_hdr.src_ip;
        tx_hdr.src_port = rx_hdr.dst_port;
        tx_hdr.dst_port = rx_hdr.src_port;
        tx_hdr.length   = rx_hdr.length;
        tx_hdr.ttl      = `UDP_REPLY_TTL;
    end

    // Payload gating stalls only on a full FIFO while echoing
    assign fifo_in       = rx_pay;
    assign fifo_in_valid = rx_pay_valid && (state == udp_echo_pkg::STEER_ECHO);
    assign rx_pay_ready  = ((state == udp_echo_pkg::STEER_ECHO) && fifo_in_ready) ||
                           (state == udp_echo_pkg::STEER_DROP);
    assign pay_last_xfer = rx_pay_valid && rx_pay_ready && rx_pay.last;

    // Decision taken once per datagram and held until the last payload beat
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= udp_echo_pkg::STEER_IDLE;
        end else begin
            case (state)
                udp_echo_pkg::STEER_IDLE: begin
                    if (hdr_xfer) begin
                        state <= port_match ? udp_echo_pkg::STEER_ECHO
                                            : udp_echo_pkg::STEER_DROP;
                    end
                end
                udp_echo_pkg::STEER_ECHO,
                udp_echo_pkg::STEER_DROP: begin
                    if (pay_last_xfer) begin
                        state <= udp_echo_pkg::STEER_IDLE;
                    end
                end
                default: begin
                    state <= udp_echo_pkg::STEER_IDLE;
                end
            endcase
        end
    end

endmodule

//--- led_first_byte.sv
`timescale 1ns/1ps

module led_first_byte (
    input  logic                     clk,
    input  logic                     rst,
    input  udp_echo_pkg::axis_byte_t beat,
    input  logic                     valid,
    input  logic                     ready,
    output logic [7:0]               led
);

    logic sof;
    logic xfer;

    assign xfer = valid && ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            sof <= 1'b1;
            led <= '0;
        end else begin
            if (xfer) begin
                // First beat of a frame goes to the LEDs
                if (sof) begin
                    led <= beat.data;
                end
                // Next frame starts after a last beat
                sof <= beat.last;
            end
        end
    end

endmodule

//--- udp_echo_core.sv
`timescale 1ns/1ps

`include "udp_echo_settings.svh"

module udp_echo_core (
    input  logic                     clk,
    input  logic                     rst,

    input  udp_echo_pkg::udp_hdr_t   rx_hdr,
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,

    input  udp_echo_pkg::axis_byte_t rx_pay,
    input  logic                     rx_pay_valid,
    output logic                     rx_pay_ready,

    output udp_echo_pkg::udp_hdr_t   tx_hdr,
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,

    output udp_echo_pkg::axis_byte_t tx_pay,
    output logic                     tx_pay_valid,
    input  logic                     tx_pay_ready,

    output logic [7:0]               led
);

    // Steering to FIFO
    udp_echo_pkg::axis_byte_t fifo_in;
    logic                     fifo_in_valid;
    logic                     fifo_in_ready;

    udp_echo_steer i_steer (
        .clk           (clk),
        .rst           (rst),
        .rx_hdr        (rx_hdr),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr_ready  (rx_hdr_ready),
        .rx_pay        (rx_pay),
        .rx_pay_valid  (rx_pay_valid),
        .rx_pay_ready  (rx_pay_ready),
        .tx_hdr        (tx_hdr),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr_ready  (tx_hdr_ready),
        .fifo_in       (fifo_in),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_ready (fifo_in_ready)
    );

    // FIFO output is the reply payload channel
    udp_payload_fifo #(
        .DEPTH (`UDP_FIFO_DEPTH)
    ) i_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (fifo_in),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_beat  (tx_pay),
        .out_valid (tx_pay_valid),
        .out_ready (tx_pay_ready)
    );

    led_first_byte i_led (
        .clk   (clk),
        .rst   (rst),
        .beat  (tx_pay),
        .valid (tx_pay_valid),
        .ready (tx_pay_ready),
        .led   (led)
    );

endmodule

//--- udp_echo_properties.sv
`timescale 1ns/1ps

`include "udp_echo_settings.svh"

module udp_echo_properties (
    input logic                     clk,
    input logic                     rst,
    input udp_echo_pkg::udp_hdr_t   rx_hdr,
    input logic                     rx_hdr_valid,
    input logic                     rx_hdr_ready,
    input udp_echo_pkg::axis_byte_t rx_pay,
    input logic                     rx_pay_valid,
    input logic                     rx_pay_ready,
    input udp_echo_pkg::udp_hdr_t   tx_hdr,
    input logic                     tx_hdr_valid,
    input logic                     tx_hdr_ready,
    input udp_echo_pkg::axis_byte_t tx_pay,
    input logic                     tx_pay_valid,
    input logic                     tx_pay_ready,
    input logic [7:0]               led
);

    // High from header accept until the last payload beat
    logic busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (rx_hdr_valid && rx_hdr_ready) begin
            busy <= 1'b1;
        end else if (rx_pay_valid && rx_pay_ready && rx_pay.last) begin
            busy <= 1'b0;
        end
    end

    tx_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        (tx_hdr_valid && !tx_hdr_ready) |=> (tx_hdr_valid && $stable(tx_hdr)))
        else $error("tx_hdr dropped valid or changed while stalled");

    tx_pay_hold: assert property (@(posedge clk) disable iff (rst)
        (tx_pay_valid && !tx_pay_ready) |=> (tx_pay_valid && $stable(tx_pay)))
        else $error("tx_pay dropped valid or changed while stalled");

    // Replies only for the echo port
    foreign_port_no_reply: assert property (@(posedge clk) disable iff (rst)
        (rx_hdr.dst_port != `UDP_ECHO_PORT) |-> !tx_hdr_valid)
        else $error("reply header offered for a foreign destination port");

    busy_no_hdr: assert property (@(posedge clk) disable iff (rst)
        busy |-> !rx_hdr_ready)
        else $error("rx_hdr_ready high while a datagram payload is in progress");

    led_after_reset: assert property (@(posedge clk)
        rst |=> (led == '0))
        else $error("led not cleared by reset");

endmodule

bind udp_echo_core udp_echo_properties i_properties (
    .clk          (clk),
    .rst          (rst),
    .rx_hdr       (rx_hdr),
    .rx_hdr_valid (rx_hdr_valid),
    .rx_hdr_ready (rx_hdr_ready),
    .rx_pay       (rx_pay),
    .rx_pay_valid (rx_pay_valid),
    .rx_pay_ready (rx_pay_ready),
    .tx_hdr       (tx_hdr),
    .tx_hdr_valid (tx_hdr_valid),
    .tx_hdr_ready (tx_hdr_ready),
    .tx_pay       (tx_pay),
    .tx_pay_valid (tx_pay_valid),
    .tx_pay_ready (tx_pay_ready),
    .led          (led)
);

//--- tb_udp_echo.sv
`timescale 1ns/1ps

`include "udp_echo_settings.svh"

module tb_udp_echo;

    localparam int CLK_NS           = 8;
    localparam int NUM_DGRAMS       = 24;
    localparam int CYCLES_PER_DGRAM = 60;
    localparam int MARGIN_NS        = 4000;
    localparam int WATCHDOG_NS      = NUM_DGRAMS * CYCLES_PER_DGRAM * CLK_NS + MARGIN_NS;
    localparam int MAX_LEN          = 40;
    localparam int BP_INDEX         = 7;
    localparam int PATTERN_LEN      = 512;

    logic                     clk;
    logic                     rst;
    udp_echo_pkg::udp_hdr_t   rx_hdr;
    logic                     rx_hdr_valid;
    logic                     rx_hdr_ready;
    udp_echo_pkg::axis_byte_t rx_pay;
    logic                     rx_pay_valid;
    logic                     rx_pay_ready;
    udp_echo_pkg::udp_hdr_t   tx_hdr;
    logic                     tx_hdr_valid;
    logic                     tx_hdr_ready;
    udp_echo_pkg::axis_byte_t tx_pay;
    logic                     tx_pay_valid;
    logic                     tx_pay_ready;
    logic [7:0]               led;

    integer seed;

    // Expected outputs that only echoed datagrams fill
    udp_echo_pkg::udp_hdr_t   hdr_q [$];
    udp_echo_pkg::axis_byte_t pay_q [$];

    // Sink ready levels per cycle that replay cyclically
    logic pay_pattern [PATTERN_LEN];
    logic hdr_pattern [PATTERN_LEN];

    logic       hold_pay;
    logic       stall_seen;
    logic [7:0] led_model;
    logic       out_sof;

    udp_echo_core i_udp_echo_core (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr       (rx_hdr),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_pay       (rx_pay),
        .rx_pay_valid (rx_pay_valid),
        .rx_pay_ready (rx_pay_ready),
        .tx_hdr       (tx_hdr),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_pay       (tx_pay),
        .tx_pay_valid (tx_pay_valid),
        .tx_pay_ready (tx_pay_ready),
        .led          (led)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_NS / 2) clk = ~clk;
        end
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic expect_equal(input string test, input logic [127:0] expected,
                                input logic [127:0] actual);
        assert (actual === expected)
        else fail_run($sformatf("ERROR %s: expected 0x%0h, actual 0x%0h",
                                test, expected, actual));
    endtask

    function automatic int rand_between(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % 32'(hi - lo + 1));
    endfunction

    // Own IP as source with ports swapped, length kept and a fixed TTL
    function automatic udp_echo_pkg::udp_hdr_t expected_reply(input udp_echo_pkg::udp_hdr_t h);
        udp_echo_pkg::udp_hdr_t rep;
        rep.src_ip   = `UDP_LOCAL_IP;
        rep.dst_ip   = h.src_ip;
        rep.src_port = h.dst_port;
        rep.dst_port = h.src_port;
        rep.length   = h.length;
        rep.ttl      = `UDP_REPLY_TTL;
        return rep;
    endfunction

    task automatic build_ready_patterns();
        int   n;
        int   pay_run;
        int   hdr_run;
        logic pay_level;
        logic hdr_level;
        pay_run   = 0;
        hdr_run   = 0;
        pay_level = 1'b0;
        hdr_level = 1'b0;
        for (n = 0; n < PATTERN_LEN; n++) begin
            if (pay_run == 0) begin
                pay_level = !pay_level;
                pay_run   = pay_level ? rand_between(1, 16) : rand_between(1, 8);
            end
            if (hdr_run == 0) begin
                hdr_level = !hdr_level;
                hdr_run   = hdr_level ? rand_between(1, 8) : rand_between(1, 4);
            end
            pay_pattern[n] = pay_level;
            hdr_pattern[n] = hdr_level;
            pay_run        = pay_run - 1;
            hdr_run        = hdr_run - 1;
        end
    endtask

    task automatic send_datagram(input logic echo, input int len);
        udp_echo_pkg::udp_hdr_t   hdr;
        udp_echo_pkg::axis_byte_t beat;
        logic [`UDP_DATA_W-1:0]   data [$];
        logic [31:0]              r;
        int                       k;
        hdr.src_ip = $random(seed);
        hdr.dst_ip = `UDP_LOCAL_IP;
        r = $random(seed);
        hdr.src_port = r[15:0];
        hdr.ttl      = r[23:16];
        hdr.length   = 16'(8 + len);
        if (echo) begin
            hdr.dst_port = `UDP_ECHO_PORT;
        end else begin
            do begin
                r = $random(seed);
                hdr.dst_port = r[15:0];
            end while (hdr.dst_port == `UDP_ECHO_PORT);
        end
        for (k = 0; k < len; k++) begin
            r = $random(seed);
            data.push_back(r[`UDP_DATA_W-1:0]);
        end
        if (echo) begin
            hdr_q.push_back(expected_reply(hdr));
            for (k = 0; k < len; k++) begin
                beat.data = data[k];
                beat.last = (k == len - 1);
                pay_q.push_back(beat);
            end
        end
        // Header beat
        @(negedge clk);
        rx_hdr       = hdr;
        rx_hdr_valid = 1'b1;
        do begin
            @(posedge clk);
        end while (!rx_hdr_ready);
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        // Payload beats with occasional idle cycles
        for (k = 0; k < len; k++) begin
            if (rand_between(0, 7) == 0) begin
                rx_pay_valid = 1'b0;
                @(negedge clk);
            end
            rx_pay.data  = data[k];
            rx_pay.last  = (k == len - 1);
            rx_pay_valid = 1'b1;
            do begin
                @(posedge clk);
                if (!rx_pay_ready && hold_pay) begin
                    stall_seen = 1'b1;
                    hold_pay   = 1'b0;
                end
            end while (!rx_pay_ready);
            @(negedge clk);
        end
        rx_pay_valid = 1'b0;
    endtask

    // Downstream sink holds ready low in stretches
    initial begin : sink_ready
        int cyc;
        cyc          = 0;
        tx_hdr_ready = 1'b0;
        tx_pay_ready = 1'b0;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            tx_hdr_ready = hdr_pattern[cyc % PATTERN_LEN];
            tx_pay_ready = hold_pay ? 1'b0 : pay_pattern[cyc % PATTERN_LEN];
            cyc          = cyc + 1;
        end
    end

    // Checks every output transfer against the expected queues
    initial begin : output_monitor
        udp_echo_pkg::udp_hdr_t   exp_hdr;
        udp_echo_pkg::axis_byte_t exp_beat;
        led_model = '0;
        out_sof   = 1'b1;
        forever begin
            @(posedge clk);
            if (rst === 1'b0) begin
                expect_equal("led", 128'(led_model), 128'(led));
                if (tx_hdr_valid && tx_hdr_ready) begin
                    assert (hdr_q.size() != 0)
                    else fail_run("ERROR drop: reply header sent for a datagram to another port");
                    exp_hdr = hdr_q.pop_front();
                    expect_equal("header_rewrite", 128'(exp_hdr), 128'(tx_hdr));
                end
                if (tx_pay_valid && tx_pay_ready) begin
                    assert (pay_q.size() != 0)
                    else fail_run("ERROR payload: output byte sent with none expected");
                    exp_beat = pay_q.pop_front();
                    expect_equal("payload", 128'(exp_beat), 128'(tx_pay));
                    if (out_sof) begin
                        led_model = exp_beat.data;
                    end
                    out_sof = exp_beat.last;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        fail_run($sformatf("ERROR watchdog: run did not finish within %0d ns", WATCHDOG_NS));
    end

    initial begin : stimulus
        int          i;
        int          len;
        logic        echo;
        logic [31:0] r;
        seed         = 32'hf2d4292c;
        rst          = 1'b1;
        rx_hdr       = '0;
        rx_hdr_valid = 1'b0;
        rx_pay       = '0;
        rx_pay_valid = 1'b0;
        hold_pay     = 1'b0;
        stall_seen   = 1'b0;
        build_ready_patterns();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        // Idle with a foreign port, so only rx_hdr_ready may be high
        expect_equal("reset_state", 128'(1'b0), 128'(tx_hdr_valid));
        expect_equal("reset_state", 128'(1'b0), 128'(tx_pay_valid));
        expect_equal("reset_state", 128'(1'b0), 128'(rx_pay_ready));
        expect_equal("reset_state", 128'(1'b1), 128'(rx_hdr_ready));
        expect_equal("reset_state", 128'(8'd0), 128'(led));
        for (i = 0; i < NUM_DGRAMS; i++) begin
            r    = $random(seed);
            echo = r[0];
            len  = rand_between(1, MAX_LEN);
            if (i == 0) begin
                echo = 1'b1;
            end
            if (i == 1) begin
                echo = 1'b0;
            end
            if (i == BP_INDEX) begin
                // Long echo that fills the FIFO while the sink stalls
                echo       = 1'b1;
                len        = MAX_LEN;
                hold_pay   = 1'b1;
                stall_seen = 1'b0;
            end
            send_datagram(echo, len);
            if (i == BP_INDEX) begin
                assert (stall_seen)
                else fail_run("ERROR backpressure: rx_pay_ready never dropped with the FIFO full");
            end
        end
        while (pay_q.size() != 0 || hdr_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (tx_pay_valid === 1'b0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_run("ERROR end: payload byte left in the FIFO after all expected bytes");
        end
    end

endmodule

//--- src.f
+incdir+.
udp_echo_pkg.sv
udp_payload_fifo.sv
udp_echo_steer.sv
led_first_byte.sv
udp_echo_core.sv
udp_echo_properties.sv
tb_udp_echo.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_udp_echo \
    -f src.f \
    -o sim_udp_echo \
    && ./obj_dir/sim_udp_echo \
    || exit 1
